/* files.f */
+incdir+source
source/bus_pkg.sv
source/periph_pkg.sv
source/word_ram.sv
source/sigma_delta_led.sv
source/interval_timer.sv
source/io_registers.sv
source/playground_bus.sv
sim/clock_gen.sv
sim/playground_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module playground_tb -o playground_sim
./obj_dir/playground_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* sim/clock_gen.sv */
//==========================================================================
// Testbench clock and reset
// 40 ns clock, synchronous reset held high for the first four cycles
//==========================================================================

`timescale 1ns/1ps

module clock_gen
#(
   parameter int HALF_PERIOD  = 20,  // ns
   parameter int RESET_CYCLES = 4
)
(
   output logic clk,
   output logic reset_button
);

   initial
   begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial
   begin
      reset_button = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_button = 1'b0;           // Released on a falling edge like the stimulus
   end

endmodule

/* sim/playground_tb.sv */
//==========================================================================
// Playground peripheral bus testbench
// Plays the processor on the memory bus and checks the memories, the IO
// access modes, GPIO, timer interrupt and LED pulse density
//==========================================================================

`timescale 1ns/1ps

`include "playground_macros.svh"

module playground_tb
   import bus_pkg::*;
   import periph_pkg::*;
();

   localparam int     MASKED_WRITES = 1000;
   localparam int     MODE_STEPS    = 200;   // Each step touches gpio_out and gpio_dir
   localparam int     GPIO_STEPS    = 50;
   localparam int     TIMER_EDGES   = 50;
   localparam int     LED_ON_CYCLES = 64;
   localparam int     SDM_WINDOW    = 65536;
   localparam int     MEM_WORDS     = `RAM_WORDS + `BOOT_WORDS;
   localparam word_t  TIMER_START   = 32'hFFFF_FFF0;  // First wrap after 16 edges
   localparam word_t  TIMER_RELOAD  = 32'hFFFF_FFE0;  // Then every 32 edges
   localparam int     RW_REGS [7]   = '{`IO_GPIO_OUT, `IO_GPIO_DIR, `IO_LEDS, `IO_SDM_RED,
                                        `IO_SDM_GREEN, `IO_SDM_BLUE, `IO_RELOAD};

   // Every bus access takes two cycles
   localparam longint TEST_CYCLES = 5 + 2 * 9                 // Reset and reset values
      + 2 * (2 * MEM_WORDS + MASKED_WRITES)                   // Fill, masked writes, reads
      + 8 * MODE_STEPS + 3 * GPIO_STEPS
      + 2 * 3 + TIMER_EDGES + 2                               // Timer
      + 2 * 8 + LED_ON_CYCLES + SDM_WINDOW;                   // LEDs
   localparam longint TIMEOUT_NS  = TEST_CYCLES * 11 / 10 * 40;

   logic   clk;
   logic   reset_button;
   addr_t  mem_address;
   word_t  mem_wdata;
   wmask_t mem_wmask;
   logic   mem_rstrb;
   word_t  mem_rdata;
   logic   interrupt;
   gpio_t  gpio_in;
   gpio_t  gpio_out;
   gpio_t  gpio_dir;
   logic   led_red;
   logic   led_green;
   logic   led_blue;
   integer seed;
   word_t  ram_model [`RAM_WORDS];   // Expected memory contents
   word_t  boot_model [`BOOT_WORDS];

   clock_gen clock_i
   (
      .clk          (clk),
      .reset_button (reset_button)
   );

   playground_bus dut_i
   (
      .clk          (clk),
      .reset_button (reset_button),
      .mem_address  (mem_address),
      .mem_wdata    (mem_wdata),
      .mem_wmask    (mem_wmask),
      .mem_rstrb    (mem_rstrb),
      .mem_rdata    (mem_rdata),
      .interrupt    (interrupt),
      .gpio_in      (gpio_in),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .led_red      (led_red),
      .led_green    (led_green),
      .led_blue     (led_blue)
   );

   // New bytes replace the old ones only where the mask is set
   function automatic word_t merge_bytes(word_t old_word, word_t new_word, wmask_t mask);
      word_t result;
      result = old_word;
      for (int lane = 0; lane < 4; lane++)
      begin
         if (mask[lane])
            result[8*lane +: 8] = new_word[8*lane +: 8];
      end
      return result;
   endfunction

   function automatic word_t io_modify(io_mode_t mode, word_t data, word_t old_value);
      case (mode)
         CLEAR:   return old_value & ~data;
         SET:     return old_value | data;
         TOGGLE:  return old_value ^ data;
         default: return data;
      endcase
   endfunction

   // Ones of a modulator over n cycles when n is a multiple of 2^16
   function automatic int sdm_ones(brightness_t brightness, int n);
      return int'((longint'(brightness) * n) >> `SDM_WIDTH);
   endfunction

   // Edges from the ticks write to the first wrap, and the reload period
   function automatic longint first_wrap();
      return 64'h1_0000_0000 - longint'(TIMER_START);
   endfunction

   function automatic longint wrap_period();
      return 64'h1_0000_0000 - longint'(TIMER_RELOAD);
   endfunction

   // Count after n edges past the ticks write
   function automatic word_t timer_ticks(longint n);
      if (n < first_wrap())
         return TIMER_START + word_t'(n);
      return TIMER_RELOAD + word_t'((n - first_wrap()) % wrap_period());
   endfunction

   function automatic logic irq_expected(longint n);
      return (n >= first_wrap()) && ((n - first_wrap()) % wrap_period() == 0);
   endfunction

   function automatic addr_t io_reg_address(int sel, io_mode_t mode);
      return {`REGION_IO, 28'h0} | (addr_t'(1) << sel) | (addr_t'(mode) << 2);
   endfunction

   task automatic fail_run();
      $display("Done: errors found");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   task automatic check_word(string name, word_t actual, word_t expected);
      if (actual !== expected)
      begin
         $display("** Error: %s = %h, expected %h", name, actual, expected);
         fail_run();
      end
   endtask

   task automatic check_gpio(string name, gpio_t actual, gpio_t expected);
      if (actual !== expected)
      begin
         $display("** Error: %s = %h, expected %h", name, actual, expected);
         fail_run();
      end
   endtask

   task automatic check_bit(string name, logic actual, logic expected);
      if (actual !== expected)
      begin
         $display("** Error: %s = %h, expected %h", name, actual, expected);
         fail_run();
      end
   endtask

   // Write takes effect at the edge between the two falling edges
   task automatic bus_write(addr_t address, word_t data, wmask_t mask);
      @(negedge clk);
      mem_address = address;
      mem_wdata   = data;
      mem_wmask   = mask;
      @(negedge clk);
      mem_wmask   = '0;
   endtask

   task automatic bus_read(input addr_t address, output word_t data);
      @(negedge clk);
      mem_address = address;
      mem_rstrb   = 1'b1;
      @(negedge clk);
      mem_rstrb   = 1'b0;
      data        = mem_rdata;       // Registered at the strobe edge
   endtask

   // One random access-mode write to a GPIO register with port and read-back checks
   task automatic modify_gpio_reg(input int sel, inout gpio_t model);
      word_t    rnd;
      word_t    data;
      word_t    rdata;
      io_mode_t mode;
      rnd   = $random(seed);
      mode  = io_mode_t'(rnd[1:0]);
      data  = $random(seed);
      model = gpio_t'(io_modify(mode, data, word_t'(model)));
      bus_write(io_reg_address(sel, mode), data, 4'hF);
      if (sel == `IO_GPIO_OUT)
         check_gpio("gpio_out", gpio_out, model);
      else
         check_gpio("gpio_dir", gpio_dir, model);
      bus_read(io_reg_address(sel, WRITE), rdata);
      check_word($sformatf("io bit %0d readback", sel), rdata, word_t'(model));
   endtask

   initial
   begin
      word_t       rnd;
      word_t       data;
      word_t       rdata;
      wmask_t      mask;
      int          index;
      gpio_t       out_model;
      gpio_t       dir_model;
      brightness_t bright [3];
      int          ones [3];
      seed        = 32'h76673014;
      mem_address = '0;
      mem_wdata   = '0;
      mem_wmask   = '0;
      mem_rstrb   = 1'b0;
      gpio_in     = '0;
      out_model   = '0;
      dir_model   = '0;
      wait (!reset_button);

      // Outputs and registers read zero after reset
      check_bit("interrupt", interrupt, 1'b0);
      check_bit("led_red", led_red, 1'b0);
      check_bit("led_green", led_green, 1'b0);
      check_bit("led_blue", led_blue, 1'b0);
      check_gpio("gpio_out", gpio_out, 8'h00);
      check_gpio("gpio_dir", gpio_dir, 8'h00);
      for (int i = 0; i < 7; i++)
      begin
         bus_read(io_reg_address(RW_REGS[i], WRITE), rdata);
         check_word($sformatf("io bit %0d after reset", RW_REGS[i]), rdata, '0);
      end

      // Fill both memories so every word is known
      for (int i = 0; i < `RAM_WORDS; i++)
      begin
         ram_model[i] = $random(seed);
         bus_write(addr_t'(i) << 2, ram_model[i], 4'hF);
      end
      for (int i = 0; i < `BOOT_WORDS; i++)
      begin
         boot_model[i] = $random(seed);
         bus_write({`REGION_BOOT, 28'h0} | (addr_t'(i) << 2), boot_model[i], 4'hF);
      end
      for (int n = 0; n < MASKED_WRITES; n++)
      begin
         data = $random(seed);
         rnd  = $random(seed);
         mask = rnd[3:0];            // Zero mask is no write at all
         if (rnd[31])
         begin
            index             = rnd[27:8] % `BOOT_WORDS;
            boot_model[index] = merge_bytes(boot_model[index], data, mask);
            bus_write({`REGION_BOOT, 28'h0} | (addr_t'(index) << 2), data, mask);
         end
         else
         begin
            index            = rnd[27:8] % `RAM_WORDS;
            ram_model[index] = merge_bytes(ram_model[index], data, mask);
            bus_write(addr_t'(index) << 2, data, mask);
         end
      end
      for (int i = 0; i < `RAM_WORDS; i++)
      begin
         bus_read(addr_t'(i) << 2, rdata);
         check_word($sformatf("ram[%0d]", i), rdata, ram_model[i]);
      end
      for (int i = 0; i < `BOOT_WORDS; i++)
      begin
         bus_read({`REGION_BOOT, 28'h0} | (addr_t'(i) << 2), rdata);
         check_word($sformatf("boot[%0d]", i), rdata, boot_model[i]);
      end

      for (int n = 0; n < MODE_STEPS; n++)
      begin
         modify_gpio_reg(`IO_GPIO_OUT, out_model);
         modify_gpio_reg(`IO_GPIO_DIR, dir_model);
      end

      // Pins settle for an edge before the read
      for (int n = 0; n < GPIO_STEPS; n++)
      begin
         rnd = $random(seed);
         @(negedge clk);
         gpio_in = rnd[7:0];
         bus_read(io_reg_address(`IO_GPIO_IN, WRITE), rdata);
         check_word("gpio_in readback", rdata, word_t'(rnd[7:0]));
      end

      // Unmapped regions read zero even after nonzero IO and memory data
      bus_read(32'h2000_0040, rdata);
      check_word("unmapped read", rdata, '0);
      bus_read(32'hC000_0100, rdata);
      check_word("unmapped read", rdata, '0);

      bus_write(io_reg_address(`IO_RELOAD, WRITE), TIMER_RELOAD, 4'hF);
      bus_write(io_reg_address(`IO_TICKS, WRITE), TIMER_START, 4'hF);
      for (int k = 1; k <= TIMER_EDGES; k++)
      begin
         @(negedge clk);             // k edges after the ticks write
         check_bit("interrupt", interrupt, irq_expected(k));
      end
      bus_read(io_reg_address(`IO_TICKS, WRITE), rdata);
      check_word("ticks", rdata, timer_ticks(TIMER_EDGES + 1));

      // Direct bits hold all LEDs on
      bus_write(io_reg_address(`IO_LEDS, WRITE), 32'h7, 4'hF);
      for (int k = 0; k < LED_ON_CYCLES; k++)
      begin
         @(negedge clk);
         check_bit("led_red", led_red, 1'b1);
         check_bit("led_green", led_green, 1'b1);
         check_bit("led_blue", led_blue, 1'b1);
      end
      bus_write(io_reg_address(`IO_LEDS, WRITE), 32'h0, 4'hF);
      for (int c = 0; c < 3; c++)
      begin
         rnd       = $random(seed);
         bright[c] = rnd[15:0];
         bus_write(io_reg_address(`IO_SDM_RED + c, WRITE), word_t'(bright[c]), 4'hF);
      end
      for (int c = 0; c < 3; c++)
      begin
         bus_read(io_reg_address(`IO_SDM_RED + c, WRITE), rdata);
         check_word($sformatf("brightness %0d", c), rdata, word_t'(bright[c]));
         ones[c] = 0;
      end
      for (int k = 0; k < SDM_WINDOW; k++)
      begin
         @(negedge clk);
         ones[0] += int'(led_red);
         ones[1] += int'(led_green);
         ones[2] += int'(led_blue);
      end
      check_word("led_red ones", word_t'(ones[0]), word_t'(sdm_ones(bright[0], SDM_WINDOW)));
      check_word("led_green ones", word_t'(ones[1]), word_t'(sdm_ones(bright[1], SDM_WINDOW)));
      check_word("led_blue ones", word_t'(ones[2]), word_t'(sdm_ones(bright[2], SDM_WINDOW)));

      $display("Done: no errors");
      $finish;
   end

   // Ends a run that outlasts all tests
   initial
   begin
      #(TIMEOUT_NS);
      $display("The run timed out after %0d ns before the tests finished", TIMEOUT_NS);
      $display("Done: errors found");
      $fatal(1, "Timeout");
   end

endmodule

/* source/bus_pkg.sv */
//==========================================================================
// Memory bus types
// Byte address, data word, byte write mask and the decoded region
//==========================================================================

`include "playground_macros.svh"

package bus_pkg;

   typedef logic [31:0] addr_t;      // Byte address from the processor
   typedef logic [31:0] word_t;      // Bus data word
   typedef logic [3:0]  wmask_t;     // One bit per byte lane

   // Region of an address, from its top nibble
   typedef enum logic [3:0]
   {
      RGN_RAM  = `REGION_RAM,
      RGN_IO   = `REGION_IO,
      RGN_BOOT = `REGION_BOOT,
      RGN_NONE = 4'hF                // Anything not mapped
   } region_t;

endpackage

/* source/interval_timer.sv */
//==========================================================================
// Reloading tick timer
// Free-running 32-bit counter, reloads on overflow and raises a
// one-cycle interrupt when it wraps
//==========================================================================

`timescale 1ns/1ps

`include "playground_macros.svh"

module interval_timer
   import bus_pkg::*;
(
   input  logic  clk,
   input  logic  reset_button,
   input  logic  ticks_wr,           // Load the counter
   input  logic  reload_wr,          // Load the reload value
   input  word_t timer_wdata,
   output word_t ticks,
   output word_t reload,
   output logic  interrupt
);

   logic [32:0] ticks_plus_1;        // Bit 32 flags the wrap
   word_t       next_ticks;

   assign ticks_plus_1 = {1'b0, ticks} + 33'd1;
   assign next_ticks   = ticks_plus_1[32] ? reload : ticks_plus_1[31:0];

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         ticks     <= `TICKS_RESET;
         reload    <= `RELOAD_RESET;
         interrupt <= 1'b0;
      end
      else
      begin
         ticks     <= ticks_wr ? timer_wdata : next_ticks;  // Bus write wins
         interrupt <= ticks_plus_1[32];                       // One cycle per wrap
         if (reload_wr)
         begin
            reload <= timer_wdata;
         end
      end
   end

endmodule

/* source/io_registers.sv */
//==========================================================================
// One-hot IO register file
// GPIO, LED and brightness registers with write, clear, set and toggle
// access, timer write strobes and a read word buffered on the strobe
//==========================================================================

`timescale 1ns/1ps

`include "playground_macros.svh"

module io_registers
   import bus_pkg::*;
   import periph_pkg::*;
(
   input  logic        clk,
   input  logic        reset_button,
   input  logic        io_wstrb,     // Write to the IO region
   input  logic        io_rstrb,     // Read from the IO region
   input  logic [19:2] io_address,
   input  word_t       io_wdata,
   input  gpio_t       gpio_in,
   output gpio_t       gpio_out,
   output gpio_t       gpio_dir,
   output led_bits_t   led_on,
   output brightness_t sdm_red,
   output brightness_t sdm_green,
   output brightness_t sdm_blue,
   input  word_t       ticks,        // Timer state, for read-back
   input  word_t       reload,
   output logic        ticks_wr,
   output logic        reload_wr,
   output word_t       timer_wdata,
   output word_t       io_rdata      // Valid one edge after io_rstrb
);

   gpio_t    gpio_in_q;              // Pins sampled once before use
   word_t    read_word;              // OR over all selected registers
   word_t    modified;               // Value to store after the access mode
   io_mode_t mode;

   always_ff @(posedge clk)
   begin
      gpio_in_q <= gpio_in;
   end

   // Several select bits may be set at once, their values are ORed
   assign read_word =
      (io_address[`IO_GPIO_IN]   ? word_t'(gpio_in_q) : '0) |
      (io_address[`IO_GPIO_OUT]  ? word_t'(gpio_out)  : '0) |
      (io_address[`IO_GPIO_DIR]  ? word_t'(gpio_dir)  : '0) |
      (io_address[`IO_LEDS]      ? word_t'(led_on)    : '0) |
      (io_address[`IO_SDM_RED]   ? word_t'(sdm_red)   : '0) |
      (io_address[`IO_SDM_GREEN] ? word_t'(sdm_green) : '0) |
      (io_address[`IO_SDM_BLUE]  ? word_t'(sdm_blue)  : '0) |
      (io_address[`IO_TICKS]     ? ticks              : '0) |
      (io_address[`IO_RELOAD]    ? reload             : '0);

   assign mode = io_mode_t'(io_address[3:2]);

   always_comb
   begin
      case (mode)
         CLEAR:   modified = ~io_wdata & read_word;
         SET:     modified =  io_wdata | read_word;
         TOGGLE:  modified =  io_wdata ^ read_word;
         default: modified =  io_wdata;              // WRITE
      endcase
   end

   // Timer registers live in the timer, it only gets the strobes
   assign ticks_wr    = io_wstrb & io_address[`IO_TICKS];
   assign reload_wr   = io_wstrb & io_address[`IO_RELOAD];
   assign timer_wdata = modified;

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         gpio_out  <= `GPIO_RESET;
         gpio_dir  <= `GPIO_RESET;
         led_on    <= `LEDS_RESET;
         sdm_red   <= `SDM_RESET;
         sdm_green <= `SDM_RESET;
         sdm_blue  <= `SDM_RESET;
      end
      else if (io_wstrb)
      begin
         if (io_address[`IO_GPIO_OUT])  gpio_out  <= modified[7:0];
         if (io_address[`IO_GPIO_DIR])  gpio_dir  <= modified[7:0];
         if (io_address[`IO_LEDS])      led_on    <= modified[2:0];
         if (io_address[`IO_SDM_RED])   sdm_red   <= modified[`SDM_WIDTH-1:0];
         if (io_address[`IO_SDM_GREEN]) sdm_green <= modified[`SDM_WIDTH-1:0];
         if (io_address[`IO_SDM_BLUE])  sdm_blue  <= modified[`SDM_WIDTH-1:0];
      end
   end

   // Hold the word of the strobe cycle for the processor
   always_ff @(posedge clk)
   begin
      if (io_rstrb)
      begin
         io_rdata <= read_word;
      end
   end

endmodule

/* source/periph_pkg.sv */
//==========================================================================
// Peripheral types
// IO access mode, GPIO byte, direct LED bits and LED brightness
//==========================================================================

`include "playground_macros.svh"

package periph_pkg;

   // Access mode, from address bits 3:2 of an IO access
   typedef enum logic [1:0]
   {
      WRITE  = 2'd0,                 // Plain write
      CLEAR  = 2'd1,                 // Clear bits set in the data
      SET    = 2'd2,                 // Set bits set in the data
      TOGGLE = 2'd3                  // Flip bits set in the data
   } io_mode_t;

   typedef logic [7:0] gpio_t;       // One GPIO port

   // Bit 0 red, bit 1 green, bit 2 blue
   typedef logic [2:0] led_bits_t;

   typedef logic [`SDM_WIDTH-1:0] brightness_t;

endpackage

/* source/playground_bus.sv */
//==========================================================================
// Playground peripheral bus, top level
// Decodes the memory bus into RAM, boot memory and IO, muxes the read
// data and hosts the timer and the three LED channels
//==========================================================================

`timescale 1ns/1ps

`include "playground_macros.svh"

module playground_bus
   import bus_pkg::*;
   import periph_pkg::*;
(
   input  logic   clk,
   input  logic   reset_button,
   input  addr_t  mem_address,
   input  word_t  mem_wdata,
   input  wmask_t mem_wmask,         // Nonzero means write this cycle
   input  logic   mem_rstrb,         // Starts a read
   output word_t  mem_rdata,
   output logic   interrupt,
   input  gpio_t  gpio_in,
   output gpio_t  gpio_out,
   output gpio_t  gpio_dir,
   output logic   led_red,
   output logic   led_green,
   output logic   led_blue
);

   localparam int RAM_AW  = $clog2(`RAM_WORDS);
   localparam int BOOT_AW = $clog2(`BOOT_WORDS);

   region_t     region;              // Region of the current address
   region_t     rd_region;           // Region of the last read
   logic        mem_wstrb;
   logic        io_wstrb;
   logic        io_rstrb;
   word_t       ram_rdata;
   word_t       boot_rdata;
   word_t       io_rdata;
   word_t       ticks;
   word_t       reload;
   logic        ticks_wr;
   logic        reload_wr;
   word_t       timer_wdata;
   led_bits_t   led_on;
   brightness_t sdm_red;
   brightness_t sdm_green;
   brightness_t sdm_blue;

   always_comb
   begin
      case (mem_address[31:28])
         `REGION_RAM:  region = RGN_RAM;
         `REGION_IO:   region = RGN_IO;
         `REGION_BOOT: region = RGN_BOOT;
         default:      region = RGN_NONE;
      endcase
   end

   assign mem_wstrb = |mem_wmask;
   assign io_wstrb  = mem_wstrb & (region == RGN_IO);
   assign io_rstrb  = mem_rstrb & (region == RGN_IO);

   // Remember where the read went, unmapped reads return zero
   always_ff @(posedge clk)
   begin
      if (reset_button)
         rd_region <= RGN_NONE;
      else if (mem_rstrb)
         rd_region <= region;
   end

   always_comb
   begin
      case (rd_region)
         RGN_RAM:  mem_rdata = ram_rdata;
         RGN_IO:   mem_rdata = io_rdata;
         RGN_BOOT: mem_rdata = boot_rdata;
         default:  mem_rdata = '0;
      endcase
   end

   word_ram #(.WORDS(`RAM_WORDS)) ram_i
   (
      .clk        (clk),
      .wmask      (mem_wmask & {4{region == RGN_RAM}}),
      .word_index (mem_address[RAM_AW+1:2]),
      .wdata      (mem_wdata),
      .rdata      (ram_rdata)
   );

   word_ram #(.WORDS(`BOOT_WORDS)) boot_i
   (
      .clk        (clk),
      .wmask      (mem_wmask & {4{region == RGN_BOOT}}),
      .word_index (mem_address[BOOT_AW+1:2]),
      .wdata      (mem_wdata),
      .rdata      (boot_rdata)
   );

   io_registers io_i
   (
      .clk          (clk),
      .reset_button (reset_button),
      .io_wstrb     (io_wstrb),
      .io_rstrb     (io_rstrb),
      .io_address   (mem_address[19:2]),
      .io_wdata     (mem_wdata),
      .gpio_in      (gpio_in),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .led_on       (led_on),
      .sdm_red      (sdm_red),
      .sdm_green    (sdm_green),
      .sdm_blue     (sdm_blue),
      .ticks        (ticks),
      .reload       (reload),
      .ticks_wr     (ticks_wr),
      .reload_wr    (reload_wr),
      .timer_wdata  (timer_wdata),
      .io_rdata     (io_rdata)
   );

   interval_timer timer_i
   (
      .clk          (clk),
      .reset_button (reset_button),
      .ticks_wr     (ticks_wr),
      .reload_wr    (reload_wr),
      .timer_wdata  (timer_wdata),
      .ticks        (ticks),
      .reload       (reload),
      .interrupt    (interrupt)
   );

   sigma_delta_led red_i
   (
      .clk          (clk),
      .reset_button (reset_button),
      .brightness   (sdm_red),
      .led_on       (led_on[0]),
      .led          (led_red)
   );

   sigma_delta_led green_i
   (
      .clk          (clk),
      .reset_button (reset_button),
      .brightness   (sdm_green),
      .led_on       (led_on[1]),
      .led          (led_green)
   );

   sigma_delta_led blue_i
   (
      .clk          (clk),
      .reset_button (reset_button),
      .brightness   (sdm_blue),
      .led_on       (led_on[2]),
      .led          (led_blue)
   );

endmodule

/* source/playground_macros.svh */
//==========================================================================
// Playground peripheral bus constants
// Address map nibbles, one-hot IO select bits, memory depths and the
// reset values of the peripheral registers
//==========================================================================

`ifndef PLAYGROUND_MACROS_SVH
`define PLAYGROUND_MACROS_SVH

// Region codes, taken from address bits 31:28
`define REGION_RAM   4'h0            // 0x0000_0000
`define REGION_IO    4'h4            // 0x4000_0000
`define REGION_BOOT  4'h8            // 0x8000_0000

// One-hot IO select bits within the IO region
`define IO_GPIO_IN   4               // R:  registered pins
`define IO_GPIO_OUT  5               // RW: output levels
`define IO_GPIO_DIR  6               // RW: output enables
`define IO_LEDS      8               // RW: direct LED bits
`define IO_SDM_RED   9               // RW: red brightness
`define IO_SDM_GREEN 10              // RW: green brightness
`define IO_SDM_BLUE  11              // RW: blue brightness
`define IO_TICKS     18              // RW: timer count
`define IO_RELOAD    19              // RW: timer reload value

// Memory depths in 32-bit words
`define RAM_WORDS    4096            // 16 KB
`define BOOT_WORDS   256             // 1 KB

// Sigma-delta modulator width
`define SDM_WIDTH    16

// Register values after reset
`define GPIO_RESET   8'h00
`define LEDS_RESET   3'b000
`define SDM_RESET    16'h0000
`define TICKS_RESET  32'h0000_0000
`define RELOAD_RESET 32'h0000_0000

`endif

/* source/sigma_delta_led.sv */
//==========================================================================
// One LED channel
// First-order sigma-delta modulator ORed with a direct on bit
//==========================================================================

`timescale 1ns/1ps

module sigma_delta_led
   import periph_pkg::*;
(
   input  logic        clk,
   input  logic        reset_button,
   input  brightness_t brightness,   // Pulse density out of 2^16
   input  logic        led_on,       // Forces the LED on
   output logic        led
);

   brightness_t phase;               // Phase accumulator
   logic        carry;               // Registered overflow of the phase

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         phase <= '0;
         carry <= 1'b0;
      end
      else
      begin
         {carry, phase} <= phase + brightness;  // Carry out is the dithered pulse
      end
   end

   assign led = led_on | carry;

endmodule

/* source/word_ram.sv */
//==========================================================================
// Byte-masked single-port word memory
// Writes the byte lanes selected by the mask and registers the addressed
// word on every clock edge
//==========================================================================

`timescale 1ns/1ps

module word_ram
   import bus_pkg::*;
#(
   parameter int WORDS = 256
)
(
   input  logic                     clk,
   input  wmask_t                   wmask,      // Already gated by region
   input  logic [$clog2(WORDS)-1:0] word_index,
   input  word_t                    wdata,
   output word_t                    rdata
);

   word_t mem [WORDS];               // Contents undefined after reset

   always_ff @(posedge clk)
   begin
      // Each lane is written on its own
      for (int lane = 0; lane < 4; lane++)
      begin
         if (wmask[lane])
         begin
            mem[word_index][8*lane +: 8] <= wdata[8*lane +: 8];
         end
      end

      rdata <= mem[word_index];      // Read before write, valid next cycle
   end

endmodule
